//--- logic/fetch_pkg.sv
package fetch_pkg;

	// memory geometry
	// 5 index bits give 32 words of two instructions each
	localparam int MEM_ADDR_BITS = 5;

	// cycles from read strobe to usable read data
	localparam int MEM_LATENCY = 3;

	// latency counter width
	// must hold MEM_LATENCY - 1
	localparam int TIMER_BITS = 2;

	// hex image of the test program
	// shared with the testbench reference model
	localparam string MEM_IMAGE = "verif/inst_image.hex";

	// program counter and fetch address
	typedef logic [63:0] addr_t;

	// one 32-bit instruction
	typedef logic [31:0] inst_t;

	// one memory word
	// low half at pc bit 2 clear, high half at pc bit 2 set
	typedef logic [63:0] mem_word_t;

	// memory word index taken from pc bits 7 down to 3
	typedef logic [MEM_ADDR_BITS-1:0] word_idx_t;

	// boot address after reset
	localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

	// controller states
	// REQUEST issues the read, WAIT covers the access time,
	// DELIVER holds until the timer reports completion
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT,
		DELIVER
	} fetch_state_t;

endpackage

//--- logic/fetch_mem_if.sv
`timescale 1ns/1ns

interface fetch_mem_if
	import fetch_pkg::*;
();

	// one-cycle read strobe from the controller
	logic rd_en;

	// word index from the pc generator
	word_idx_t word_idx;

	// registered read data from the memory
	mem_word_t rdata;

	// read data is valid for the current fetch
	logic take;

	// controller side
	modport ctrl (
		output rd_en,
		output take
	);

	// pc generator side
	modport pcgen (
		output word_idx,
		input  take,
		input  rdata
	);

	// memory side
	modport mem (
		input  rd_en,
		input  word_idx,
		output rdata
	);

endinterface

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl
	import fetch_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      fetch_en,
	input  logic      pc_update,
	input  logic      done,
	output logic      start,
	output logic      busy,
	output logic      redirect_pend,
	fetch_mem_if.ctrl mem
);

	fetch_state_t state;
	fetch_state_t state_next;

	// redirect seen while a fetch was in flight
	// the target address itself is kept in pc_gen
	logic pend_q;

	// state register
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// next state
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// wait here until fetching is enabled
				if (fetch_en) begin
					state_next = REQUEST;
				end
			end
			REQUEST: begin
				// read strobe and timer start go out this cycle
				state_next = WAIT;
			end
			WAIT: begin
				// memory still busy with the access
				state_next = DELIVER;
			end
			DELIVER: begin
				// stay until the timer reports the word ready
				if (done) begin
					// back to back fetch when still enabled
					if (fetch_en) begin
						state_next = REQUEST;
					end else begin
						state_next = IDLE;
					end
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// read strobe and timer load share the REQUEST cycle
	assign mem.rd_en = (state == REQUEST);
	assign start     = (state == REQUEST);

	// take lasts exactly one cycle since DELIVER is left on done
	assign mem.take = (state == DELIVER) && done;

	// any state but IDLE has a fetch in flight
	assign busy = (state != IDLE);

	// pending flag
	// set by a redirect during a fetch, consumed at take
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_q <= 1'b0;
		end else if (mem.take) begin
			pend_q <= 1'b0;
		end else if (busy && pc_update) begin
			// a later pulse simply keeps the flag set
			pend_q <= 1'b1;
		end
	end

	// a pulse in the take cycle also drops the word
	assign redirect_pend = pend_q || (busy && pc_update);

endmodule

//--- logic/latency_timer.sv
`timescale 1ns/1ns

module latency_timer
	import fetch_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic done
);

	// cycles left until the read data is usable
	logic [TIMER_BITS-1:0] count;

	// load value
	// start cycle plus MEM_LATENCY-1 counted cycles ends on the data cycle
	localparam logic [TIMER_BITS-1:0] LOAD_VAL = TIMER_BITS'(MEM_LATENCY - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (start) begin
			count <= LOAD_VAL;
		end else if (count != '0) begin
			// count down and park at zero
			count <= count - 1'b1;
		end
	end

	// level output
	// low while a new start is being issued
	assign done = (count == '0) && !start;

endmodule

//--- logic/pc_gen.sv
`timescale 1ns/1ns

module pc_gen
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       pc_update,
	input  addr_t      dnpc,
	input  logic       busy,
	input  logic       redirect_pend,
	output addr_t      pc,
	output inst_t      inst,
	output logic       inst_valid,
	fetch_mem_if.pcgen mem
);

	// redirect target captured while a fetch is in flight
	addr_t dnpc_q;

	// sequential next address
	addr_t pc_plus4;

	// where a dropped fetch continues
	addr_t redirect_target;

	// instruction half picked from the read word
	inst_t inst_sel;

	assign pc_plus4 = pc + 64'd4;

	// a pulse in the take cycle wins over the older captured target
	assign redirect_target = pc_update ? dnpc : dnpc_q;

	// pc bit 2 chooses the upper or lower instruction of the word
	assign inst_sel = pc[2] ? mem.rdata[63:32] : mem.rdata[31:0];

	// memory word index comes straight from the pc
	assign mem.word_idx = pc[MEM_ADDR_BITS+2:3];

	// captured target
	// the newest pulse overwrites an older one
	always_ff @(posedge clk) begin
		if (busy && pc_update) begin
			dnpc_q <= dnpc;
		end
	end

	// program counter
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (mem.take) begin
			if (redirect_pend) begin
				pc <= redirect_target;
			end else begin
				pc <= pc_plus4;
			end
		end else if (!busy && pc_update) begin
			// nothing in flight so the redirect applies at once
			pc <= dnpc;
		end
	end

	// instruction output register and its strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			inst       <= '0;
			inst_valid <= 1'b0;
		end else begin
			// strobe is high for one cycle only
			inst_valid <= 1'b0;
			if (mem.take && !redirect_pend) begin
				inst       <= inst_sel;
				inst_valid <= 1'b1;
			end
			// inst keeps its last value between strobes
		end
	end

endmodule

//--- logic/inst_mem.sv
`timescale 1ns/1ns

module inst_mem
	import fetch_pkg::*;
(
	input logic      clk,
	fetch_mem_if.mem mem
);

	// number of words in the array
	localparam int DEPTH = 2 ** MEM_ADDR_BITS;

	// program storage
	mem_word_t words [DEPTH];

	// registered read data
	mem_word_t rdata_q;

	// preload the test program
	initial begin
		$readmemh(MEM_IMAGE, words);
	end

	// read port
	// the register is only written on a strobe,
	// so the word stays put over the whole access window
	always_ff @(posedge clk) begin
		if (mem.rd_en) begin
			rdata_q <= words[mem.word_idx];
		end
	end

	assign mem.rdata = rdata_q;

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  fetch_en,
	input  logic  pc_update,
	input  addr_t dnpc,
	output addr_t pc,
	output inst_t inst,
	output logic  inst_valid
);

	// controller to timer
	logic start;
	logic done;

	// controller to pc generator
	logic busy;
	logic redirect_pend;

	// read strobe, index, data and take between the blocks
	fetch_mem_if mem_bus ();

	// fetch sequencing and pending redirect flag
	fetch_ctrl u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.fetch_en      (fetch_en),
		.pc_update     (pc_update),
		.done          (done),
		.start         (start),
		.busy          (busy),
		.redirect_pend (redirect_pend),
		.mem           (mem_bus.ctrl)
	);

	// models the fixed access time of the memory
	latency_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.done  (done)
	);

	// pc, redirect target and instruction output
	pc_gen u_pc_gen (
		.clk           (clk),
		.reset         (reset),
		.pc_update     (pc_update),
		.dnpc          (dnpc),
		.busy          (busy),
		.redirect_pend (redirect_pend),
		.pc            (pc),
		.inst          (inst),
		.inst_valid    (inst_valid),
		.mem           (mem_bus.pcgen)
	);

	// program storage with registered read
	inst_mem u_mem (
		.clk (clk),
		.mem (mem_bus.mem)
	);

endmodule

//--- verif/fetch_unit_props.sv
`timescale 1ns/1ns

module fetch_unit_props
	import fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic rd_en,
	input logic take,
	input logic pc_update,
	input logic inst_valid
);

	// redirect pulse seen since the current read strobe
	// a pulse in the strobe cycle itself already counts
	logic redirect_seen;

	// the word under a redirect is dropped at take
	logic drop;

	always_ff @(posedge clk) begin
		if (reset) begin
			redirect_seen <= 1'b0;
		end else if (rd_en) begin
			redirect_seen <= pc_update;
		end else if (pc_update) begin
			redirect_seen <= 1'b1;
		end
	end

	// a pulse in the take cycle also counts
	assign drop = redirect_seen || pc_update;

	// quiet through reset and the first cycle after it
	quiet_around_reset: assert property (@(posedge clk)
		reset |=> !rd_en && !inst_valid)
		else $error("read strobe or inst_valid active around reset");

	// strobe never lasts two cycles
	single_valid: assert property (@(posedge clk) disable iff (reset)
		inst_valid |=> !inst_valid)
		else $error("inst_valid high two cycles in a row");

	// a take with no redirect since the read strobe delivers one cycle later
	take_delivers: assert property (@(posedge clk) disable iff (reset)
		take && !drop |=> inst_valid)
		else $error("take without a redirect in flight gave no inst_valid");

	// a redirect in flight drops the word
	take_drops: assert property (@(posedge clk) disable iff (reset)
		take && drop |=> !inst_valid)
		else $error("word delivered although a redirect was in flight");

	// and nothing else raises the strobe
	valid_from_take: assert property (@(posedge clk) disable iff (reset)
		inst_valid |-> $past(take))
		else $error("inst_valid without a preceding take");

	// one fetch in flight means no new read inside the access window
	one_in_flight: assert property (@(posedge clk) disable iff (reset)
		rd_en |=> !rd_en [*MEM_LATENCY])
		else $error("read strobe while a fetch was in flight");

endmodule

bind fetch_unit fetch_unit_props u_props (
	.clk        (clk),
	.reset      (reset),
	.rd_en      (mem_bus.rd_en),
	.take       (mem_bus.take),
	.pc_update  (pc_update),
	.inst_valid (inst_valid)
);

//--- verif/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb
	import fetch_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	// cycles per fetch with fetch_en held high
	localparam int FETCH_CYCLES = MEM_LATENCY + 1;

	// test lengths in fetch slots
	localparam int SEQ_LEN    = 16;
	localparam int WRAP_LEN   = 54;
	localparam int IDLE_LEN   = 8;
	localparam int FLIGHT_LEN = 12;
	localparam int PAUSE_LEN  = 12;
	localparam int TOTAL_LEN  = SEQ_LEN + WRAP_LEN + IDLE_LEN + FLIGHT_LEN + PAUSE_LEN;

	logic  clk;
	logic  reset;
	logic  fetch_en;
	logic  pc_update;
	addr_t dnpc;
	addr_t pc;
	inst_t inst;
	logic  inst_valid;

	// own copy of the program image
	mem_word_t image [2 ** MEM_ADDR_BITS];

	// address whose instruction the next strobe should carry
	addr_t exp_pc;

	int n_valid;
	int n_checks;
	int n_errors;
	int cycle_no;
	int last_valid_cycle;
	int last_gap;

	logic [15:0] lfsr_state;

	fetch_unit dut (
		.clk        (clk),
		.reset      (reset),
		.fetch_en   (fetch_en),
		.pc_update  (pc_update),
		.dnpc       (dnpc),
		.pc         (pc),
		.inst       (inst),
		.inst_valid (inst_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// word from address bits 7..3 with the half picked by bit 2
	function automatic inst_t expected_inst(input addr_t addr);
		mem_word_t word;
		word = image[addr[7:3]];
		return addr[2] ? word[63:32] : word[31:0];
	endfunction

	// 16-bit Galois step with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic random_bits(input int width, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check(input logic ok, input string what);
		n_checks++;
		assert (ok) else begin
			$display("FAILED %0t: %s", $time, what);
			n_errors++;
		end
	endtask

	task automatic wait_deliveries(input int count);
		int target;
		target = n_valid + count;
		wait (n_valid >= target);
	endtask

	// one-cycle pulse entered on a falling edge
	task automatic apply_redirect(input addr_t target);
		pc_update = 1'b1;
		dnpc      = target;
		exp_pc    = target;
		@(negedge clk);
		pc_update = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s done, %0d errors", name, n_errors - errors_before);
	endtask

	// compares every strobe against the reference model
	initial begin : compare
		forever begin
			@(posedge clk);
			cycle_no++;
			if (inst_valid === 1'b1) begin
				check(inst === expected_inst(exp_pc),
					$sformatf("inst %h for address %h, expected %h",
					inst, exp_pc, expected_inst(exp_pc)));
				exp_pc = exp_pc + 64'd4;
				// pc already points at the next fetch
				check(pc === exp_pc, $sformatf("pc %h, expected %h", pc, exp_pc));
				last_gap         = cycle_no - last_valid_cycle;
				last_valid_cycle = cycle_no;
				n_valid++;
			end
		end
	end

	initial begin : stimulus
		int          errs;
		int          hold;
		logic [31:0] r;
		logic [31:0] k;

		clk        = 1'b0;
		reset      = 1'b1;
		fetch_en   = 1'b0;
		pc_update  = 1'b0;
		dnpc       = '0;
		lfsr_state = 16'd94;
		exp_pc     = RESET_PC;
		$readmemh(MEM_IMAGE, image);

		repeat (5) @(posedge clk);
		@(negedge clk);
		check(pc === RESET_PC && inst === '0 && inst_valid === 1'b0,
			"outputs not at reset values");
		reset    = 1'b0;
		fetch_en = 1'b1;

		// sequential fetch from the boot address
		errs = n_errors;
		wait_deliveries(1);
		for (int i = 1; i < SEQ_LEN; i++) begin
			wait_deliveries(1);
			check(last_gap == FETCH_CYCLES, $sformatf("strobe gap %0d cycles", last_gap));
		end
		report_test("sequential fetch", errs);

		// keep going past word 31
		errs = n_errors;
		for (int i = 0; i < WRAP_LEN; i++) begin
			wait_deliveries(1);
			check(last_gap == FETCH_CYCLES, $sformatf("strobe gap %0d cycles", last_gap));
		end
		check(pc - RESET_PC > 64'd256, "pc never advanced past word 31");
		report_test("word wrap", errs);

		// redirect while idle
		errs = n_errors;
		@(negedge clk);
		fetch_en = 1'b0;
		// fetch already started still comes out
		wait_deliveries(1);
		random_bits(2, k);
		repeat (k + 1) @(negedge clk);
		random_bits(6, r);
		apply_redirect(RESET_PC + {r[5:0], 2'b00});
		check(pc === exp_pc, "pc did not load dnpc while idle");
		fetch_en = 1'b1;
		wait_deliveries(IDLE_LEN - 1);
		report_test("idle redirect", errs);

		// redirect during a fetch with two pulses in the last round
		errs = n_errors;
		for (int i = 0; i < FLIGHT_LEN / 3; i++) begin
			wait_deliveries(1);
			random_bits(2, k);
			k = (i == FLIGHT_LEN / 3 - 1) ? k % 2 : k % 3;
			@(negedge clk);
			repeat (k) @(negedge clk);
			random_bits(6, r);
			apply_redirect(RESET_PC + {r[5:0], 2'b00});
			if (i == FLIGHT_LEN / 3 - 1) begin
				random_bits(6, r);
				apply_redirect(RESET_PC + {r[5:0], 2'b00});
			end
			wait_deliveries(1);
			check(last_gap == 2 * FETCH_CYCLES, "fetch under redirect was not dropped");
		end
		report_test("redirect in flight", errs);

		// pause mid-fetch
		errs = n_errors;
		wait_deliveries(1);
		random_bits(2, k);
		@(negedge clk);
		repeat (k % 3) @(negedge clk);
		fetch_en = 1'b0;
		wait_deliveries(1);
		hold = n_valid;
		repeat (3 * FETCH_CYCLES) @(negedge clk);
		check(n_valid == hold, "instruction delivered while fetch_en was low");
		check(pc === exp_pc, "pc moved during the pause");
		fetch_en = 1'b1;
		// pause takes five slots of the test length
		wait_deliveries(PAUSE_LEN - 5);
		report_test("pause", errs);

		$display("%0d checks, %0d errors, %0d instructions delivered",
			n_checks, n_errors, n_valid);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// limit from the summed test lengths plus margin for reset and pauses
	initial begin : watchdog
		#(TOTAL_LEN * FETCH_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
		$display("timeout: the run did not finish, the DUT stopped delivering instructions");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- fetch_unit.f
logic/fetch_pkg.sv
logic/fetch_mem_if.sv
logic/fetch_ctrl.sv
logic/latency_timer.sv
logic/pc_gen.sv
logic/inst_mem.sv
logic/fetch_unit.sv
verif/fetch_unit_props.sv
verif/fetch_unit_tb.sv

//--- verif/inst_image.hex
// one 64-bit word per line, word 0 first; high 8 digits at pc bit 2 set, low 8 at bit 2 clear
8B0022977A000113
8B0122977A010113
8B0222977A020113
8B0322977A030113
8B0422977A040113
8B0522977A050113
8B0622977A060113
8B0722977A070113
8B0822977A080113
8B0922977A090113
8B0A22977A0A0113
8B0B22977A0B0113
8B0C22977A0C0113
8B0D22977A0D0113
8B0E22977A0E0113
8B0F22977A0F0113
8B1022977A100113
8B1122977A110113
8B1222977A120113
8B1322977A130113
8B1422977A140113
8B1522977A150113
8B1622977A160113
8B1722977A170113
8B1822977A180113
8B1922977A190113
8B1A22977A1A0113
8B1B22977A1B0113
8B1C22977A1C0113
8B1D22977A1D0113
8B1E22977A1E0113
8B1F22977A1F0113
